// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_dmem_subsys
FILELIST  := dmem_subsys.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := design/dmem_subsys_cfg.svh
VECTORS   := test/dmem_subsys_vectors.txt

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) $(VECTORS)
	./$(SIM_BIN) | tee $(SIM_LOG)
	grep -q "^sim passed$$" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// ==== design/dmem_router.sv ====
`include "dmem_subsys_cfg.svh"

module dmem_router (
    input  logic                         core_clk,
    input  logic                         reset_i,
    // Core side
    input  logic                         dmem_req_i,
    input  dmem_subsys_pkg::dmem_cmd_e   dmem_cmd_i,
    input  dmem_subsys_pkg::dmem_width_e dmem_width_i,
    input  dmem_subsys_pkg::dmem_addr_t  dmem_addr_i,
    input  dmem_subsys_pkg::dmem_data_t  dmem_wdata_i,
    output logic                         dmem_req_ack_o,
    output dmem_subsys_pkg::dmem_data_t  dmem_rdata_o,
    output dmem_subsys_pkg::dmem_resp_e  dmem_resp_o,
    // Timer port
    output logic                         tmr_req_o,
    output dmem_subsys_pkg::dmem_cmd_e   tmr_cmd_o,
    output dmem_subsys_pkg::dmem_width_e tmr_width_o,
    output dmem_subsys_pkg::dmem_addr_t  tmr_addr_o,
    output dmem_subsys_pkg::dmem_data_t  tmr_wdata_o,
    input  logic                         tmr_req_ack_i,
    input  dmem_subsys_pkg::dmem_data_t  tmr_rdata_i,
    input  dmem_subsys_pkg::dmem_resp_e  tmr_resp_i,
    // Wishbone bridge port
    output logic                         wbp_req_o,
    output dmem_subsys_pkg::dmem_cmd_e   wbp_cmd_o,
    output dmem_subsys_pkg::dmem_width_e wbp_width_o,
    output dmem_subsys_pkg::dmem_addr_t  wbp_addr_o,
    output dmem_subsys_pkg::dmem_data_t  wbp_wdata_o,
    input  logic                         wbp_req_ack_i,
    input  dmem_subsys_pkg::dmem_data_t  wbp_rdata_i,
    input  dmem_subsys_pkg::dmem_resp_e  wbp_resp_i
);

dmem_subsys_pkg::router_state_e state_q, state_d;
logic sel_tmr;   // Address hits timer window
logic idle;

assign sel_tmr = ((dmem_addr_i & `TIMER_MASK) == `TIMER_BASE);
assign idle    = (state_q == dmem_subsys_pkg::RT_IDLE);

// ----------------------------------------
// Request steering
// ----------------------------------------
assign tmr_req_o      = idle & dmem_req_i & sel_tmr;
assign wbp_req_o      = idle & dmem_req_i & ~sel_tmr;
assign dmem_req_ack_o = idle & (sel_tmr ? tmr_req_ack_i : wbp_req_ack_i);  // Low while waiting

// Fields go to both, only one req is raised
assign tmr_cmd_o   = dmem_cmd_i;
assign tmr_width_o = dmem_width_i;
assign tmr_addr_o  = dmem_addr_i;
assign tmr_wdata_o = dmem_wdata_i;
assign wbp_cmd_o   = dmem_cmd_i;
assign wbp_width_o = dmem_width_i;
assign wbp_addr_o  = dmem_addr_i;
assign wbp_wdata_o = dmem_wdata_i;

// Response from the owing port only
always_comb begin
    case (state_q)
        dmem_subsys_pkg::RT_WAIT_TIMER: begin
            dmem_resp_o  = tmr_resp_i;
            dmem_rdata_o = tmr_rdata_i;
        end
        dmem_subsys_pkg::RT_WAIT_WB: begin
            dmem_resp_o  = wbp_resp_i;
            dmem_rdata_o = wbp_rdata_i;
        end
        default: begin
            dmem_resp_o  = dmem_subsys_pkg::RESP_IDLE;
            dmem_rdata_o = '0;
        end
    endcase
end

// ----------------------------------------
// Pending-port tracking
// ----------------------------------------
always_comb begin
    state_d = state_q;
    case (state_q)
        dmem_subsys_pkg::RT_IDLE: begin
            if (dmem_req_i && dmem_req_ack_o) begin
                state_d = sel_tmr ? dmem_subsys_pkg::RT_WAIT_TIMER
                                  : dmem_subsys_pkg::RT_WAIT_WB;
            end
        end
        dmem_subsys_pkg::RT_WAIT_TIMER: begin
            if (tmr_resp_i != dmem_subsys_pkg::RESP_IDLE) state_d = dmem_subsys_pkg::RT_IDLE;
        end
        dmem_subsys_pkg::RT_WAIT_WB: begin
            if (wbp_resp_i != dmem_subsys_pkg::RESP_IDLE) state_d = dmem_subsys_pkg::RT_IDLE;
        end
        default: state_d = dmem_subsys_pkg::RT_IDLE;
    endcase
end

always_ff @(posedge core_clk) begin
    if (reset_i) state_q <= dmem_subsys_pkg::RT_IDLE;
    else         state_q <= state_d;
end

// Stray responses mean a target answered without a request
a_no_stray_tmr_resp: assert property (@(posedge core_clk) disable iff (reset_i)
    (tmr_resp_i != dmem_subsys_pkg::RESP_IDLE) |-> (state_q == dmem_subsys_pkg::RT_WAIT_TIMER));
a_no_stray_wbp_resp: assert property (@(posedge core_clk) disable iff (reset_i)
    (wbp_resp_i != dmem_subsys_pkg::RESP_IDLE) |-> (state_q == dmem_subsys_pkg::RT_WAIT_WB));

endmodule

// ==== design/dmem_subsys_cfg.svh ====
`ifndef DMEM_SUBSYS_CFG_SVH
`define DMEM_SUBSYS_CFG_SVH

// Bus widths, data and Wishbone share one width
`define DMEM_AWIDTH         32
`define DMEM_DWIDTH         32

// ----------------------------------------
// Timer window, 32 bytes
// ----------------------------------------
`define TIMER_BASE          32'hF000_0040
`define TIMER_MASK          32'hFFFF_FFE0

// Register byte offsets inside the window
`define TIMER_OFS_CTRL      5'h00   // Bit 0 enable
`define TIMER_OFS_DIV       5'h04
`define TIMER_OFS_MTIME_LO  5'h08
`define TIMER_OFS_MTIME_HI  5'h0C
`define TIMER_OFS_CMP_LO    5'h10
`define TIMER_OFS_CMP_HI    5'h14

`define TIMER_DIV_WIDTH     10      // Prescaler width

`endif

// ==== design/dmem_subsys_pkg.sv ====
`include "dmem_subsys_cfg.svh"

package dmem_subsys_pkg;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------
    typedef logic [`DMEM_AWIDTH-1:0]   dmem_addr_t;
    typedef logic [`DMEM_DWIDTH-1:0]   dmem_data_t;
    typedef logic [`DMEM_DWIDTH/8-1:0] dmem_byte_sel_t;   // One bit per lane
    typedef logic [63:0]               mtime_t;

    // Core request encodings
    typedef enum logic [1:0] {
        WIDTH_BYTE  = 2'b00,
        WIDTH_HWORD = 2'b01,
        WIDTH_WORD  = 2'b10
    } dmem_width_e;

    typedef enum logic [1:0] {
        RESP_IDLE = 2'b00,   // No response this cycle
        RESP_OK   = 2'b01,
        RESP_ERR  = 2'b10
    } dmem_resp_e;

    typedef enum logic {CMD_READ = 1'b0, CMD_WRITE = 1'b1} dmem_cmd_e;

    // State machines
    typedef enum logic [1:0] {RT_IDLE, RT_WAIT_TIMER, RT_WAIT_WB} router_state_e;
    typedef enum logic [1:0] {WB_IDLE, WB_BUSY, WB_DONE} wb_state_e;

endpackage

// ==== design/dmem_subsys_top.sv ====
module dmem_subsys_top (
    input  logic                            core_clk,
    input  logic                            reset_i,
    // Core data port
    input  logic                            dmem_req_i,
    input  dmem_subsys_pkg::dmem_cmd_e      dmem_cmd_i,
    input  dmem_subsys_pkg::dmem_width_e    dmem_width_i,
    input  dmem_subsys_pkg::dmem_addr_t     dmem_addr_i,
    input  dmem_subsys_pkg::dmem_data_t     dmem_wdata_i,
    output logic                            dmem_req_ack_o,
    output dmem_subsys_pkg::dmem_data_t     dmem_rdata_o,
    output dmem_subsys_pkg::dmem_resp_e     dmem_resp_o,
    // Wishbone master
    output logic                            wb_stb_o,
    output logic                            wb_cyc_o,
    output logic                            wb_we_o,
    output dmem_subsys_pkg::dmem_addr_t     wb_adr_o,
    output dmem_subsys_pkg::dmem_data_t     wb_dat_o,
    output dmem_subsys_pkg::dmem_byte_sel_t wb_sel_o,
    input  dmem_subsys_pkg::dmem_data_t     wb_dat_i,
    input  logic                            wb_ack_i,
    input  logic                            wb_err_i,
    output logic                            timer_irq_o
);

// ----------------------------------------
// Router to timer
// ----------------------------------------
logic                         tmr_req, tmr_req_ack;
dmem_subsys_pkg::dmem_cmd_e   tmr_cmd;
dmem_subsys_pkg::dmem_width_e tmr_width;
dmem_subsys_pkg::dmem_addr_t  tmr_addr;
dmem_subsys_pkg::dmem_data_t  tmr_wdata, tmr_rdata;
dmem_subsys_pkg::dmem_resp_e  tmr_resp;

// Router to Wishbone bridge
logic                         wbp_req, wbp_req_ack;
dmem_subsys_pkg::dmem_cmd_e   wbp_cmd;
dmem_subsys_pkg::dmem_width_e wbp_width;
dmem_subsys_pkg::dmem_addr_t  wbp_addr;
dmem_subsys_pkg::dmem_data_t  wbp_wdata, wbp_rdata;
dmem_subsys_pkg::dmem_resp_e  wbp_resp;

dmem_router i_dmem_router (
    .core_clk       (core_clk),         .reset_i       (reset_i),
    // Core side
    .dmem_req_i     (dmem_req_i),       .dmem_cmd_i    (dmem_cmd_i),
    .dmem_width_i   (dmem_width_i),     .dmem_addr_i   (dmem_addr_i),
    .dmem_wdata_i   (dmem_wdata_i),     .dmem_req_ack_o(dmem_req_ack_o),
    .dmem_rdata_o   (dmem_rdata_o),     .dmem_resp_o   (dmem_resp_o),
    // Timer port
    .tmr_req_o      (tmr_req),          .tmr_cmd_o     (tmr_cmd),
    .tmr_width_o    (tmr_width),        .tmr_addr_o    (tmr_addr),
    .tmr_wdata_o    (tmr_wdata),        .tmr_req_ack_i (tmr_req_ack),
    .tmr_rdata_i    (tmr_rdata),        .tmr_resp_i    (tmr_resp),
    // Bridge port
    .wbp_req_o      (wbp_req),          .wbp_cmd_o     (wbp_cmd),
    .wbp_width_o    (wbp_width),        .wbp_addr_o    (wbp_addr),
    .wbp_wdata_o    (wbp_wdata),        .wbp_req_ack_i (wbp_req_ack),
    .wbp_rdata_i    (wbp_rdata),        .wbp_resp_i    (wbp_resp)
);

mm_timer i_mm_timer (
    .core_clk   (core_clk),     .reset_i    (reset_i),
    .req_i      (tmr_req),      .cmd_i      (tmr_cmd),
    .width_i    (tmr_width),    .addr_i     (tmr_addr),
    .wdata_i    (tmr_wdata),    .req_ack_o  (tmr_req_ack),
    .rdata_o    (tmr_rdata),    .resp_o     (tmr_resp),
    .timer_irq_o(timer_irq_o)
);

dmem_wb_bridge i_dmem_wb_bridge (
    .core_clk   (core_clk),     .reset_i    (reset_i),
    .req_i      (wbp_req),      .cmd_i      (wbp_cmd),
    .width_i    (wbp_width),    .addr_i     (wbp_addr),
    .wdata_i    (wbp_wdata),    .req_ack_o  (wbp_req_ack),
    .rdata_o    (wbp_rdata),    .resp_o     (wbp_resp),
    // External bus
    .wb_stb_o   (wb_stb_o),     .wb_cyc_o   (wb_cyc_o),
    .wb_we_o    (wb_we_o),      .wb_adr_o   (wb_adr_o),
    .wb_dat_o   (wb_dat_o),     .wb_sel_o   (wb_sel_o),
    .wb_dat_i   (wb_dat_i),     .wb_ack_i   (wb_ack_i),
    .wb_err_i   (wb_err_i)
);

endmodule

// ==== design/dmem_wb_bridge.sv ====
`include "dmem_subsys_cfg.svh"

module dmem_wb_bridge (
    input  logic                            core_clk,
    input  logic                            reset_i,
    // Request port from router
    input  logic                            req_i,
    input  dmem_subsys_pkg::dmem_cmd_e      cmd_i,
    input  dmem_subsys_pkg::dmem_width_e    width_i,
    input  dmem_subsys_pkg::dmem_addr_t     addr_i,
    input  dmem_subsys_pkg::dmem_data_t     wdata_i,
    output logic                            req_ack_o,
    output dmem_subsys_pkg::dmem_data_t     rdata_o,
    output dmem_subsys_pkg::dmem_resp_e     resp_o,
    // Wishbone master
    output logic                            wb_stb_o,
    output logic                            wb_cyc_o,
    output logic                            wb_we_o,
    output dmem_subsys_pkg::dmem_addr_t     wb_adr_o,
    output dmem_subsys_pkg::dmem_data_t     wb_dat_o,
    output dmem_subsys_pkg::dmem_byte_sel_t wb_sel_o,
    input  dmem_subsys_pkg::dmem_data_t     wb_dat_i,
    input  logic                            wb_ack_i,
    input  logic                            wb_err_i
);

dmem_subsys_pkg::wb_state_e      state_q;
dmem_subsys_pkg::dmem_addr_t     adr_q;     // Word aligned
dmem_subsys_pkg::dmem_data_t     dat_q;
dmem_subsys_pkg::dmem_byte_sel_t sel_q;
logic                            we_q;
dmem_subsys_pkg::dmem_data_t     rdata_q;   // Whole bus word
logic                            err_q;
dmem_subsys_pkg::dmem_byte_sel_t sel_d;
dmem_subsys_pkg::dmem_data_t     dat_d;
logic                            acc_fire;
logic                            term;      // Slave ends the cycle

assign req_ack_o = (state_q == dmem_subsys_pkg::WB_IDLE);
assign acc_fire  = req_i & req_ack_o;
assign term      = wb_ack_i | wb_err_i;

// ----------------------------------------
// Byte lanes from width and low address
// ----------------------------------------
always_comb begin
    case (width_i)
        dmem_subsys_pkg::WIDTH_BYTE: begin
            sel_d = 4'b0001 << addr_i[1:0];
            dat_d = {{(`DMEM_DWIDTH-8){1'b0}}, wdata_i[7:0]} << {addr_i[1:0], 3'b000};
        end
        dmem_subsys_pkg::WIDTH_HWORD: begin
            sel_d = 4'b0011 << {addr_i[1], 1'b0};
            dat_d = {{(`DMEM_DWIDTH-16){1'b0}}, wdata_i[15:0]} << {addr_i[1], 4'b0000};
        end
        default: begin   // Full word
            sel_d = 4'b1111;
            dat_d = wdata_i;
        end
    endcase
end

// ----------------------------------------
// Cycle sequencing
// ----------------------------------------
always_ff @(posedge core_clk) begin
    if (reset_i) begin
        state_q <= dmem_subsys_pkg::WB_IDLE;
    end else begin
        case (state_q)
            dmem_subsys_pkg::WB_IDLE: if (acc_fire) state_q <= dmem_subsys_pkg::WB_BUSY;
            dmem_subsys_pkg::WB_BUSY: if (term) state_q <= dmem_subsys_pkg::WB_DONE;
            default:                  state_q <= dmem_subsys_pkg::WB_IDLE;  // Resp cycle
        endcase
    end
end

// Request held until ack or err
always_ff @(posedge core_clk) begin
    if (acc_fire) begin
        adr_q <= {addr_i[`DMEM_AWIDTH-1:2], 2'b00};
        dat_q <= dat_d;
        sel_q <= sel_d;
        we_q  <= (cmd_i == dmem_subsys_pkg::CMD_WRITE);
    end
    if (state_q == dmem_subsys_pkg::WB_BUSY && term) begin
        rdata_q <= wb_dat_i;
        err_q   <= wb_err_i;
    end
end

assign wb_stb_o = (state_q == dmem_subsys_pkg::WB_BUSY);
assign wb_cyc_o = wb_stb_o;        // Single transfer per cycle
assign wb_we_o  = we_q;
assign wb_adr_o = adr_q;
assign wb_dat_o = dat_q;
assign wb_sel_o = sel_q;

assign rdata_o = rdata_q;
assign resp_o  = (state_q != dmem_subsys_pkg::WB_DONE) ? dmem_subsys_pkg::RESP_IDLE :
                 err_q ? dmem_subsys_pkg::RESP_ERR : dmem_subsys_pkg::RESP_OK;

// Slave sees a steady request through its wait states
a_wb_req_stable: assert property (@(posedge core_clk) disable iff (reset_i)
    (wb_stb_o && !wb_ack_i && !wb_err_i)
        |=> ($stable(wb_adr_o) && $stable(wb_sel_o) && $stable(wb_we_o)));

endmodule

// ==== design/mm_timer.sv ====
`include "dmem_subsys_cfg.svh"

module mm_timer (
    input  logic                         core_clk,
    input  logic                         reset_i,
    // Register access port
    input  logic                         req_i,
    input  dmem_subsys_pkg::dmem_cmd_e   cmd_i,
    input  dmem_subsys_pkg::dmem_width_e width_i,
    input  dmem_subsys_pkg::dmem_addr_t  addr_i,
    input  dmem_subsys_pkg::dmem_data_t  wdata_i,
    output logic                         req_ack_o,
    output dmem_subsys_pkg::dmem_data_t  rdata_o,
    output dmem_subsys_pkg::dmem_resp_e  resp_o,
    // Compare interrupt
    output logic                         timer_irq_o
);

logic                        en_q;        // ctrl bit 0
logic [`TIMER_DIV_WIDTH-1:0] div_q;       // Count every div+1 cycles
logic [`TIMER_DIV_WIDTH-1:0] div_cnt_q;
dmem_subsys_pkg::mtime_t     mtime_q;
dmem_subsys_pkg::mtime_t     mtimecmp_q;
dmem_subsys_pkg::dmem_resp_e resp_q;
dmem_subsys_pkg::dmem_data_t rdata_q;
dmem_subsys_pkg::dmem_data_t rd_val;      // Selected register
logic [4:0]                  ofs;
logic                        acc_ok;      // Word access to known offset
logic                        acc_fire;
logic                        wr_fire;
logic                        tick;

assign ofs       = addr_i[4:0];
assign req_ack_o = (resp_q == dmem_subsys_pkg::RESP_IDLE);  // Busy only while answering
assign acc_fire  = req_i & req_ack_o;
assign wr_fire   = acc_fire & acc_ok & (cmd_i == dmem_subsys_pkg::CMD_WRITE);
assign tick      = en_q & (div_cnt_q >= div_q);

// ----------------------------------------
// Register decode
// ----------------------------------------
always_comb begin
    acc_ok = (width_i == dmem_subsys_pkg::WIDTH_WORD);
    rd_val = '0;
    case (ofs)
        `TIMER_OFS_CTRL:     rd_val = {{(`DMEM_DWIDTH-1){1'b0}}, en_q};
        `TIMER_OFS_DIV:      rd_val = {{(`DMEM_DWIDTH-`TIMER_DIV_WIDTH){1'b0}}, div_q};
        `TIMER_OFS_MTIME_LO: rd_val = mtime_q[31:0];
        `TIMER_OFS_MTIME_HI: rd_val = mtime_q[63:32];
        `TIMER_OFS_CMP_LO:   rd_val = mtimecmp_q[31:0];
        `TIMER_OFS_CMP_HI:   rd_val = mtimecmp_q[63:32];
        default:             acc_ok = 1'b0;   // Hole in the map
    endcase
end

// Response one cycle after acceptance
always_ff @(posedge core_clk) begin
    if (reset_i) begin
        resp_q <= dmem_subsys_pkg::RESP_IDLE;
    end else if (acc_fire) begin
        resp_q <= acc_ok ? dmem_subsys_pkg::RESP_OK : dmem_subsys_pkg::RESP_ERR;
    end else begin
        resp_q <= dmem_subsys_pkg::RESP_IDLE;
    end
end

always_ff @(posedge core_clk) begin
    if (acc_fire) rdata_q <= rd_val;
end

assign resp_o  = resp_q;
assign rdata_o = rdata_q;

// ----------------------------------------
// Control and compare registers
// ----------------------------------------
always_ff @(posedge core_clk) begin
    if (reset_i) begin
        en_q       <= 1'b1;     // Counting out of reset
        div_q      <= '0;
        mtimecmp_q <= '1;       // Keeps irq low
    end else if (wr_fire) begin
        case (ofs)
            `TIMER_OFS_CTRL:   en_q              <= wdata_i[0];
            `TIMER_OFS_DIV:    div_q             <= wdata_i[`TIMER_DIV_WIDTH-1:0];
            `TIMER_OFS_CMP_LO: mtimecmp_q[31:0]  <= wdata_i;
            `TIMER_OFS_CMP_HI: mtimecmp_q[63:32] <= wdata_i;
            default: ;
        endcase
    end
end

// Divider and counter, software write wins over a tick
always_ff @(posedge core_clk) begin
    if (reset_i) begin
        div_cnt_q <= '0;
        mtime_q   <= '0;
    end else begin
        if (!en_q || tick) div_cnt_q <= '0;
        else               div_cnt_q <= div_cnt_q + `TIMER_DIV_WIDTH'(1);
        if (wr_fire && ofs == `TIMER_OFS_MTIME_LO)      mtime_q[31:0]  <= wdata_i;
        else if (wr_fire && ofs == `TIMER_OFS_MTIME_HI) mtime_q[63:32] <= wdata_i;
        else if (tick)                                  mtime_q <= mtime_q + 64'd1;
    end
end

assign timer_irq_o = (mtime_q >= mtimecmp_q);   // Level, held until cmp moves

// Never answers unasked
a_resp_after_accept: assert property (@(posedge core_clk) disable iff (reset_i)
    (resp_o != dmem_subsys_pkg::RESP_IDLE) |-> $past(acc_fire));

endmodule

// ==== dmem_subsys.f ====
+incdir+design
design/dmem_subsys_pkg.sv
design/dmem_router.sv
design/mm_timer.sv
design/dmem_wb_bridge.sv
design/dmem_subsys_top.sv
test/dmem_subsys_checker.sv
test/tb_dmem_subsys.sv

// ==== test/dmem_subsys_checker.sv ====
module dmem_subsys_checker (
    input  logic                        core_clk,
    input  logic                        reset_i,
    // DUT outputs under watch
    input  dmem_subsys_pkg::dmem_resp_e dmem_resp_i,
    input  dmem_subsys_pkg::dmem_data_t dmem_rdata_i,
    input  logic                        timer_irq_i,
    // Expected values from the driver
    input  logic                        exp_valid_i,
    input  dmem_subsys_pkg::dmem_data_t exp_rdata_i,
    input  dmem_subsys_pkg::dmem_resp_e exp_resp_i,
    input  logic                        check_rdata_i,
    input  logic                        check_incr_i,     // Read must beat the last one
    input  logic                        check_irq_i,      // One-cycle strobe
    input  logic                        exp_irq_i,
    input  logic [1:0]                  timeout_code_i,   // 1 ack, 2 resp, 3 irq
    output int unsigned                 mismatch_cnt_o,
    output int unsigned                 fail_cnt_o
);
timeunit 1ns;
timeprecision 1ps;

dmem_subsys_pkg::dmem_data_t prev_rdata = '0;   // Data of the last response
int unsigned                 mism_cnt   = 0;
int unsigned                 fail_cnt   = 0;

assign mismatch_cnt_o = mism_cnt;
assign fail_cnt_o     = fail_cnt;

// ----------------------------------------
// Response and read data
// ----------------------------------------
always @(posedge core_clk) begin
    if (!reset_i && dmem_resp_i != dmem_subsys_pkg::RESP_IDLE) begin
        if (!exp_valid_i) begin
            $display("%0d ns: response %s arrived with no request outstanding",
                     $time, dmem_resp_i.name());
            fail_cnt = fail_cnt + 1;
        end else begin
            if (dmem_resp_i !== exp_resp_i) begin
                $display("Mismatch at %0d ns: dmem_resp_o expected %s, got %s",
                         $time, exp_resp_i.name(), dmem_resp_i.name());
                mism_cnt = mism_cnt + 1;
            end
            if (check_rdata_i && dmem_rdata_i !== exp_rdata_i) begin
                $display("Mismatch at %0d ns: dmem_rdata_o expected %h, got %h",
                         $time, exp_rdata_i, dmem_rdata_i);
                mism_cnt = mism_cnt + 1;
            end
            if (check_incr_i && !(dmem_rdata_i > prev_rdata)) begin   // Counter moved on
                $display("Mismatch at %0d ns: dmem_rdata_o expected above %h, got %h",
                         $time, prev_rdata, dmem_rdata_i);
                mism_cnt = mism_cnt + 1;
            end
        end
        prev_rdata = dmem_rdata_i;
    end
end

// Interrupt level after a compare write
always @(posedge core_clk) begin
    if (!reset_i && check_irq_i && timer_irq_i !== exp_irq_i) begin
        $display("Mismatch at %0d ns: timer_irq_o expected %b, got %b",
                 $time, exp_irq_i, timer_irq_i);
        mism_cnt = mism_cnt + 1;
    end
end

// ----------------------------------------
// Timeouts seen by the driver
// ----------------------------------------
always @(posedge core_clk) begin
    case (timeout_code_i)
        2'd1: $display("%0d ns: the request was never accepted", $time);
        2'd2: $display("%0d ns: no response came back for an accepted request", $time);
        2'd3: $display("%0d ns: the timer interrupt never reached its expected level", $time);
        default: ;
    endcase
    if (timeout_code_i != 2'd0) fail_cnt = fail_cnt + 1;
end

endmodule

// ==== test/dmem_subsys_vectors.txt ====
# op(0 rd 1 wr) width(0 byte 1 half 2 word) addr wdata exp_rdata exp_resp(1 ok 2 err) flags
# flags bit0 check rdata, bit1 rdata above last read, bit2 check irq, bit3 expected irq
1 2 00000010 cafef00d 00000000 1 0
0 2 00000010 00000000 cafef00d 1 1
1 2 00000020 11223344 00000000 1 0
1 0 00000020 000000aa 00000000 1 0
1 0 00000021 000000bb 00000000 1 0
1 0 00000022 000000cc 00000000 1 0
1 0 00000023 000000dd 00000000 1 0
0 2 00000020 00000000 ddccbbaa 1 1
1 2 00000024 55667788 00000000 1 0
1 1 00000026 0000abcd 00000000 1 0
1 1 00000024 00001234 00000000 1 0
0 2 00000024 00000000 abcd1234 1 1
1 2 90000000 deadbeef 00000000 2 0
0 2 80000004 00000000 00000000 2 0
1 2 f0000050 12345678 00000000 1 4
1 2 f0000054 000000a5 00000000 1 4
0 2 f0000050 00000000 12345678 1 1
0 2 f0000054 00000000 000000a5 1 1
0 1 f0000048 00000000 00000000 2 0
0 2 f0000058 00000000 00000000 2 0
0 2 f0000048 00000000 00000000 1 0
0 2 f0000048 00000000 00000000 1 2
1 2 f0000050 00000000 00000000 1 4
1 2 f0000054 00000000 00000000 1 c
1 2 f0000054 ffffffff 00000000 1 4
1 2 f0000050 ffffffff 00000000 1 4

// ==== test/tb_dmem_subsys.sv ====
module tb_dmem_subsys;
timeunit 1ns;
timeprecision 1ps;

localparam int ACK_LIMIT  = 40;   // Cycles allowed per wait loop
localparam int RESP_LIMIT = 40;
localparam int IRQ_LIMIT  = 20;

logic                            core_clk;
logic                            reset_i;
logic                            dmem_req_i;
dmem_subsys_pkg::dmem_cmd_e      dmem_cmd_i;
dmem_subsys_pkg::dmem_width_e    dmem_width_i;
dmem_subsys_pkg::dmem_addr_t     dmem_addr_i;
dmem_subsys_pkg::dmem_data_t     dmem_wdata_i;
logic                            dmem_req_ack_o;
dmem_subsys_pkg::dmem_data_t     dmem_rdata_o;
dmem_subsys_pkg::dmem_resp_e     dmem_resp_o;
logic                            wb_stb_o, wb_cyc_o, wb_we_o;
dmem_subsys_pkg::dmem_addr_t     wb_adr_o;
dmem_subsys_pkg::dmem_data_t     wb_dat_o;
dmem_subsys_pkg::dmem_byte_sel_t wb_sel_o;
dmem_subsys_pkg::dmem_data_t     wb_dat_i;
logic                            wb_ack_i, wb_err_i;
logic                            timer_irq_o;

// Expected values for the checker
logic                            exp_valid, check_rdata, check_incr, check_irq, exp_irq;
dmem_subsys_pkg::dmem_data_t     exp_rdata;
dmem_subsys_pkg::dmem_resp_e     exp_resp;
logic [1:0]                      timeout_code;
int unsigned                     mismatch_cnt, fail_cnt;
logic [31:0]                     mem [64];   // Slave memory, word indexed

dmem_subsys_top DUT (
    .core_clk(core_clk), .reset_i(reset_i),
    .dmem_req_i(dmem_req_i), .dmem_cmd_i(dmem_cmd_i), .dmem_width_i(dmem_width_i),
    .dmem_addr_i(dmem_addr_i), .dmem_wdata_i(dmem_wdata_i),
    .dmem_req_ack_o(dmem_req_ack_o), .dmem_rdata_o(dmem_rdata_o), .dmem_resp_o(dmem_resp_o),
    .wb_stb_o(wb_stb_o), .wb_cyc_o(wb_cyc_o), .wb_we_o(wb_we_o), .wb_adr_o(wb_adr_o),
    .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel_o), .wb_dat_i(wb_dat_i),
    .wb_ack_i(wb_ack_i), .wb_err_i(wb_err_i), .timer_irq_o(timer_irq_o)
);

dmem_subsys_checker CHK (
    .core_clk(core_clk), .reset_i(reset_i),
    .dmem_resp_i(dmem_resp_o), .dmem_rdata_i(dmem_rdata_o), .timer_irq_i(timer_irq_o),
    .exp_valid_i(exp_valid), .exp_rdata_i(exp_rdata), .exp_resp_i(exp_resp),
    .check_rdata_i(check_rdata), .check_incr_i(check_incr),
    .check_irq_i(check_irq), .exp_irq_i(exp_irq), .timeout_code_i(timeout_code),
    .mismatch_cnt_o(mismatch_cnt), .fail_cnt_o(fail_cnt)
);

initial begin
    core_clk = 1'b0;
    forever #50 core_clk = ~core_clk;   // 100 ns period
end

// ----------------------------------------
// Wishbone slave memory
// ----------------------------------------
initial begin
    int          dly;
    int          idx;
    int          b;
    wb_ack_i = 1'b0;
    wb_err_i = 1'b0;
    wb_dat_i = '0;
    void'($urandom(32'h3d56_e861));   // Only process drawing numbers
    for (idx = 0; idx < 64; idx++) begin
        mem[idx] = 32'hA5A5_0000 ^ (32'(idx) * 32'h0001_0101);
    end
    dly = -1;
    forever begin
        @(posedge core_clk);
        if (wb_ack_i || wb_err_i) begin   // Single-cycle termination
            wb_ack_i <= 1'b0;
            wb_err_i <= 1'b0;
            dly = -1;
        end else if (wb_stb_o && wb_cyc_o) begin
            if (dly < 0) dly = int'($urandom % 4);   // 0..3 wait states
            if (dly > 0) begin
                dly--;
            end else if (wb_adr_o[31]) begin
                wb_err_i <= 1'b1;                   // Upper half is unmapped
            end else begin
                idx = int'(wb_adr_o[7:2]);
                wb_ack_i <= 1'b1;
                wb_dat_i <= mem[idx];
                for (b = 0; b < 4; b++) begin
                    if (wb_we_o && wb_sel_o[b]) mem[idx][8*b +: 8] = wb_dat_o[8*b +: 8];
                end
            end
        end
    end
end

// One-cycle timeout code to the checker
task automatic report_timeout(input logic [1:0] code);
    timeout_code <= code;
    @(posedge core_clk);
    timeout_code <= 2'd0;
endtask

// ----------------------------------------
// One transaction from the vector file
// ----------------------------------------
task automatic send_request(input logic [31:0] op, width, addr, wdata, rdata, resp, flags,
                            output bit ok);
    int cnt;
    ok = 1'b1;
    @(posedge core_clk);
    dmem_req_i   <= 1'b1;
    dmem_cmd_i   <= dmem_subsys_pkg::dmem_cmd_e'(op[0]);
    dmem_width_i <= dmem_subsys_pkg::dmem_width_e'(width[1:0]);
    dmem_addr_i  <= addr;
    dmem_wdata_i <= wdata;
    exp_valid    <= 1'b1;
    exp_rdata    <= rdata;
    exp_resp     <= dmem_subsys_pkg::dmem_resp_e'(resp[1:0]);
    check_rdata  <= flags[0];
    check_incr   <= flags[1];
    exp_irq      <= flags[3];
    cnt = 0;
    do begin   // Acceptance edge sees req and ack together
        @(posedge core_clk);
        cnt++;
    end while (!dmem_req_ack_o && cnt < ACK_LIMIT);
    dmem_req_i <= 1'b0;
    if (!dmem_req_ack_o) begin
        exp_valid <= 1'b0;
        report_timeout(2'd1);
        ok = 1'b0;
        return;
    end
    cnt = 0;
    do begin
        @(posedge core_clk);
        cnt++;
    end while (dmem_resp_o == dmem_subsys_pkg::RESP_IDLE && cnt < RESP_LIMIT);
    exp_valid   <= 1'b0;   // Checker compared on this edge
    check_rdata <= 1'b0;
    check_incr  <= 1'b0;
    if (dmem_resp_o == dmem_subsys_pkg::RESP_IDLE) begin
        report_timeout(2'd2);
        ok = 1'b0;
        return;
    end
    if (flags[2]) begin   // Irq level settles after the write
        cnt = 0;
        while (timer_irq_o !== flags[3] && cnt < IRQ_LIMIT) begin
            @(posedge core_clk);
            cnt++;
        end
        if (timer_irq_o !== flags[3]) report_timeout(2'd3);
        check_irq <= 1'b1;
        @(posedge core_clk);
        check_irq <= 1'b0;
    end
endtask

initial begin
    int          fd;
    int          n_vec;
    int          tb_errs;
    bit          ok;
    bit          abort;
    string       line;
    logic [31:0] v_op, v_width, v_addr, v_wdata, v_rdata, v_resp, v_flags;
    reset_i      = 1'b1;
    dmem_req_i   = 1'b0;
    dmem_cmd_i   = dmem_subsys_pkg::CMD_READ;
    dmem_width_i = dmem_subsys_pkg::WIDTH_WORD;
    dmem_addr_i  = '0;
    dmem_wdata_i = '0;
    exp_valid    = 1'b0;
    exp_rdata    = '0;
    exp_resp     = dmem_subsys_pkg::RESP_IDLE;
    check_rdata  = 1'b0;
    check_incr   = 1'b0;
    check_irq    = 1'b0;
    exp_irq      = 1'b0;
    timeout_code = 2'd0;
    n_vec        = 0;
    tb_errs      = 0;
    abort        = 1'b0;
    repeat (8) @(posedge core_clk);
    reset_i <= 1'b0;
    fd = $fopen("test/dmem_subsys_vectors.txt", "r");
    if (fd == 0) begin
        $display("Could not open the vector file test/dmem_subsys_vectors.txt");
        tb_errs++;
    end
    while (fd != 0 && !abort && $fgets(line, fd) > 0) begin
        if (line.len() == 0 || line[0] == "#") continue;   // Column notes
        if ($sscanf(line, "%h %h %h %h %h %h %h", v_op, v_width, v_addr, v_wdata,
                    v_rdata, v_resp, v_flags) != 7) continue;
        send_request(v_op, v_width, v_addr, v_wdata, v_rdata, v_resp, v_flags, ok);
        n_vec++;
        if (!ok) abort = 1'b1;   // DUT stuck, stop driving
    end
    if (fd != 0) $fclose(fd);
    if (fd != 0 && n_vec == 0) begin
        $display("The vector file held no transactions");
        tb_errs++;
    end
    repeat (3) @(posedge core_clk);
    $display("Errors: %0d mismatches, %0d other failures over %0d transactions",
             mismatch_cnt, fail_cnt + tb_errs, n_vec);
    if (mismatch_cnt == 0 && fail_cnt == 0 && tb_errs == 0) begin
        $display("sim passed");
    end else begin
        $display("sim failed");
    end
    $finish;
end

endmodule
